// File: hdl/lc4_pkg.sv
package lc4_pkg;

    typedef logic [15:0] word_t;
    typedef logic [2:0]  reg_sel_t;
    typedef logic [2:0]  nzp_t;

    // condition codes, negative bit on top
    localparam nzp_t NZP_N = 3'b100;
    localparam nzp_t NZP_Z = 3'b010;
    localparam nzp_t NZP_P = 3'b001;

    localparam logic [3:0] OP_BR    = 4'b0000;
    localparam logic [3:0] OP_ARITH = 4'b0001;
    localparam logic [3:0] OP_LDR   = 4'b0110;
    localparam logic [3:0] OP_STR   = 4'b0111;
    localparam logic [3:0] OP_CONST = 4'b1001;

    // arith sub-ops; any sub-op with bit 2 set is add with imm5
    localparam logic [2:0] SUB_ADD = 3'b000;
    localparam logic [2:0] SUB_SUB = 3'b010;

    localparam word_t RESET_PC = 16'h8200;
    localparam int    NUM_REGS = 8;

    typedef union packed {
        struct packed {
            logic [3:0] opcode;
            reg_sel_t   rd;
            reg_sel_t   rs;
            logic [2:0] sub;
            reg_sel_t   rt;
        } rrr;
        struct packed {
            logic [3:0] opcode;
            reg_sel_t   rd;
            reg_sel_t   rs;
            logic [5:0] imm6;
        } mem;
        struct packed {
            logic [3:0] opcode;
            nzp_t       nzp;
            logic [8:0] imm9;
        } br;
    } lc4_insn_t;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_PASS_IMM
    } alu_op_t;

    typedef struct packed {
        logic     valid;
        reg_sel_t rs_sel;
        reg_sel_t rt_sel;
        reg_sel_t rd_sel;
        logic     rs_re;
        logic     rt_re;
        logic     rf_we;
        logic     nzp_we;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
        nzp_t     br_nzp;
        alu_op_t  alu_op;
        logic     use_imm;
        word_t    imm;
    } ctrl_t;

    typedef struct packed {
        logic  we;
        word_t addr;
        word_t wdata;
    } dmem_req_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    insn;
        logic     rf_we;
        reg_sel_t wsel;
        word_t    wdata;
        nzp_t     nzp;
    } retire_t;

    // sign class of a 16-bit value
    function automatic nzp_t nzp_of(word_t value);
        return (value == '0) ? NZP_Z : (value[15] ? NZP_N : NZP_P);
    endfunction

endpackage

// File: hdl/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit (
    input  logic           gwe,
    input  logic           i_arst_n,
    input  logic           i_stall,
    input  logic           i_redirect,
    input  lc4_pkg::word_t i_target,
    input  lc4_pkg::word_t i_imem_insn,
    output lc4_pkg::word_t o_imem_addr,
    output lc4_pkg::word_t o_fd_pc,
    output lc4_pkg::word_t o_fd_insn,
    output logic           o_fd_valid
);
    import lc4_pkg::*;

    word_t pc_q;

    assign o_imem_addr = pc_q;

    // a redirect wins over a stall, the stalled instruction is being flushed
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q       <= RESET_PC;
            o_fd_valid <= 1'b0;
        end else if (i_redirect) begin
            pc_q       <= i_target;
            o_fd_valid <= 1'b0;
        end else if (!i_stall) begin
            pc_q       <= pc_q + 16'd1;
            o_fd_valid <= 1'b1;
        end
    end

    always_ff @(posedge gwe) begin
        if (!i_stall) begin
            o_fd_pc   <= pc_q;
            o_fd_insn <= i_imem_insn;
        end
    end

endmodule

// File: hdl/regfile.sv
`timescale 1ns/100ps

module regfile (
    input  logic              gwe,
    input  logic              i_arst_n,
    input  lc4_pkg::reg_sel_t i_rs_sel,
    input  lc4_pkg::reg_sel_t i_rt_sel,
    input  lc4_pkg::reg_sel_t i_wsel,
    input  logic              i_we,
    input  lc4_pkg::word_t    i_wdata,
    output lc4_pkg::word_t    o_rs_data,
    output lc4_pkg::word_t    o_rt_data
);
    import lc4_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_wsel] <= i_wdata;
        end
    end

    // same-cycle write is visible to the reader
    assign o_rs_data = (i_we && i_wsel == i_rs_sel) ? i_wdata : regs[i_rs_sel];
    assign o_rt_data = (i_we && i_wsel == i_rt_sel) ? i_wdata : regs[i_rt_sel];

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic              gwe,
    input  logic              i_arst_n,
    input  lc4_pkg::word_t    i_fd_pc,
    input  lc4_pkg::word_t    i_fd_insn,
    input  logic              i_fd_valid,
    input  logic              i_redirect,
    input  logic              i_wb_we,
    input  lc4_pkg::reg_sel_t i_wb_sel,
    input  lc4_pkg::word_t    i_wb_data,
    output logic              o_stall,
    output lc4_pkg::ctrl_t    o_dx_ctrl,
    output lc4_pkg::word_t    o_dx_pc,
    output lc4_pkg::word_t    o_dx_insn,
    output lc4_pkg::word_t    o_dx_rs,
    output lc4_pkg::word_t    o_dx_rt
);
    import lc4_pkg::*;

    lc4_insn_t insn;
    ctrl_t     ctrl;
    word_t     rs_data;
    word_t     rt_data;
    logic      rs_dep;
    logic      rt_dep;

    assign insn = i_fd_insn;

    always_comb begin
        ctrl        = '0;
        ctrl.rs_sel = insn.rrr.rs;
        ctrl.rt_sel = insn.rrr.rt;
        ctrl.rd_sel = insn.rrr.rd;
        case (insn.rrr.opcode)
            OP_BR: begin
                ctrl.is_branch = 1'b1;
                ctrl.br_nzp    = insn.br.nzp;
                ctrl.imm       = {{7{insn.br.imm9[8]}}, insn.br.imm9};
            end
            OP_ARITH: begin
                ctrl.rs_re   = insn.rrr.sub[2] || insn.rrr.sub == SUB_ADD ||
                               insn.rrr.sub == SUB_SUB;
                ctrl.rf_we   = ctrl.rs_re;
                ctrl.nzp_we  = ctrl.rs_re;
                ctrl.rt_re   = insn.rrr.sub == SUB_ADD || insn.rrr.sub == SUB_SUB;
                ctrl.use_imm = insn.rrr.sub[2];
                ctrl.alu_op  = (insn.rrr.sub == SUB_SUB) ? ALU_SUB : ALU_ADD;
                // imm5 sits in the low five bits
                ctrl.imm     = {{11{insn.rrr.sub[1]}}, insn.rrr.sub[1:0], insn.rrr.rt};
            end
            OP_LDR: begin
                ctrl.rs_re   = 1'b1;
                ctrl.rf_we   = 1'b1;
                ctrl.nzp_we  = 1'b1;
                ctrl.is_load = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.imm     = {{10{insn.mem.imm6[5]}}, insn.mem.imm6};
            end
            OP_STR: begin
                // store data comes from the rd field
                ctrl.rt_sel   = insn.mem.rd;
                ctrl.rs_re    = 1'b1;
                ctrl.rt_re    = 1'b1;
                ctrl.is_store = 1'b1;
                ctrl.use_imm  = 1'b1;
                ctrl.imm      = {{10{insn.mem.imm6[5]}}, insn.mem.imm6};
            end
            OP_CONST: begin
                ctrl.rf_we   = 1'b1;
                ctrl.nzp_we  = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.alu_op  = ALU_PASS_IMM;
                ctrl.imm     = {{7{insn.br.imm9[8]}}, insn.br.imm9};
            end
            default: begin
                // anything outside the subset retires with no effect
            end
        endcase
        ctrl.valid = 1'b1;
        if (!i_fd_valid) begin
            ctrl = '0;
        end
    end

    regfile regfile_i (
        .gwe      (gwe),
        .i_arst_n (i_arst_n),
        .i_rs_sel (ctrl.rs_sel),
        .i_rt_sel (ctrl.rt_sel),
        .i_wsel   (i_wb_sel),
        .i_we     (i_wb_we),
        .i_wdata  (i_wb_data),
        .o_rs_data(rs_data),
        .o_rt_data(rt_data)
    );

    // load in execute feeding this instruction, branches wait for the load nzp
    assign rs_dep  = ctrl.rs_re && ctrl.rs_sel == o_dx_ctrl.rd_sel;
    assign rt_dep  = ctrl.rt_re && ctrl.rt_sel == o_dx_ctrl.rd_sel;
    assign o_stall = o_dx_ctrl.is_load && (rs_dep || rt_dep || ctrl.is_branch);

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_dx_ctrl <= '0;
        end else if (o_stall || i_redirect) begin
            o_dx_ctrl <= '0;
        end else begin
            o_dx_ctrl <= ctrl;
        end
    end

    always_ff @(posedge gwe) begin
        o_dx_pc   <= i_fd_pc;
        o_dx_insn <= i_fd_insn;
        o_dx_rs   <= rs_data;
        o_dx_rt   <= rt_data;
    end

endmodule

// File: hdl/exec_stage.sv
`timescale 1ns/100ps

module exec_stage (
    input  logic           gwe,
    input  logic           i_arst_n,
    input  lc4_pkg::ctrl_t i_dx_ctrl,
    input  lc4_pkg::word_t i_dx_pc,
    input  lc4_pkg::word_t i_dx_insn,
    input  lc4_pkg::word_t i_dx_rs,
    input  lc4_pkg::word_t i_dx_rt,
    input  lc4_pkg::ctrl_t i_m_ctrl,
    input  lc4_pkg::word_t i_m_result,
    input  lc4_pkg::ctrl_t i_w_ctrl,
    input  lc4_pkg::word_t i_w_data,
    input  logic           i_load_nzp_we,
    input  lc4_pkg::nzp_t  i_load_nzp,
    output logic           o_redirect,
    output lc4_pkg::word_t o_target,
    output lc4_pkg::ctrl_t o_xm_ctrl,
    output lc4_pkg::word_t o_xm_pc,
    output lc4_pkg::word_t o_xm_insn,
    output lc4_pkg::word_t o_xm_result,
    output lc4_pkg::word_t o_xm_store
);
    import lc4_pkg::*;

    word_t rs_val;
    word_t rt_val;
    word_t opnd_b;
    word_t result;
    nzp_t  nzp_q;

    // M beats W beats the register value; a load in M has no data yet
    function automatic word_t bypass(reg_sel_t sel, logic re, word_t rf_val,
                                     ctrl_t m_ctrl, word_t m_val,
                                     ctrl_t w_ctrl, word_t w_val);
        if (re && m_ctrl.rf_we && !m_ctrl.is_load && m_ctrl.rd_sel == sel) begin
            return m_val;
        end
        if (re && w_ctrl.rf_we && w_ctrl.rd_sel == sel) begin
            return w_val;
        end
        return rf_val;
    endfunction

    assign rs_val = bypass(i_dx_ctrl.rs_sel, i_dx_ctrl.rs_re, i_dx_rs,
                           i_m_ctrl, i_m_result, i_w_ctrl, i_w_data);
    assign rt_val = bypass(i_dx_ctrl.rt_sel, i_dx_ctrl.rt_re, i_dx_rt,
                           i_m_ctrl, i_m_result, i_w_ctrl, i_w_data);

    assign opnd_b = i_dx_ctrl.use_imm ? i_dx_ctrl.imm : rt_val;

    always_comb begin
        case (i_dx_ctrl.alu_op)
            ALU_ADD:      result = rs_val + opnd_b;
            ALU_SUB:      result = rs_val - opnd_b;
            ALU_PASS_IMM: result = i_dx_ctrl.imm;
            default:      result = '0;
        endcase
    end

    // the younger alu write in X wins over the load finishing in M
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            nzp_q <= NZP_Z;
        end else if (i_dx_ctrl.valid && i_dx_ctrl.nzp_we && !i_dx_ctrl.is_load) begin
            nzp_q <= nzp_of(result);
        end else if (i_load_nzp_we) begin
            nzp_q <= i_load_nzp;
        end
    end

    assign o_redirect = i_dx_ctrl.valid && i_dx_ctrl.is_branch &&
                        (i_dx_ctrl.br_nzp & nzp_q) != '0;
    assign o_target   = i_dx_pc + 16'd1 + i_dx_ctrl.imm;

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_xm_ctrl <= '0;
        end else begin
            o_xm_ctrl <= i_dx_ctrl;
        end
    end

    always_ff @(posedge gwe) begin
        o_xm_pc     <= i_dx_pc;
        o_xm_insn   <= i_dx_insn;
        o_xm_result <= result;
        o_xm_store  <= rt_val;
    end

endmodule

// File: hdl/mem_wb_stage.sv
`timescale 1ns/100ps

module mem_wb_stage (
    input  logic               gwe,
    input  logic               i_arst_n,
    input  lc4_pkg::ctrl_t     i_xm_ctrl,
    input  lc4_pkg::word_t     i_xm_pc,
    input  lc4_pkg::word_t     i_xm_result,
    input  lc4_pkg::word_t     i_xm_store,
    input  lc4_pkg::word_t     i_xm_insn,
    input  lc4_pkg::word_t     i_dmem_rdata,
    output lc4_pkg::dmem_req_t o_dmem,
    output logic               o_load_nzp_we,
    output lc4_pkg::nzp_t      o_load_nzp,
    output lc4_pkg::ctrl_t     o_w_ctrl,
    output lc4_pkg::word_t     o_w_data,
    output lc4_pkg::retire_t   o_retire
);
    import lc4_pkg::*;

    word_t w_pc;
    word_t w_insn;
    word_t w_result;
    word_t w_rdata;

    // the address is the alu result, data was bypassed in execute
    assign o_dmem.we    = i_xm_ctrl.valid && i_xm_ctrl.is_store;
    assign o_dmem.addr  = i_xm_result;
    assign o_dmem.wdata = i_xm_store;

    assign o_load_nzp_we = i_xm_ctrl.valid && i_xm_ctrl.is_load;
    assign o_load_nzp    = nzp_of(i_dmem_rdata);

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_w_ctrl <= '0;
        end else begin
            o_w_ctrl <= i_xm_ctrl;
        end
    end

    always_ff @(posedge gwe) begin
        w_pc     <= i_xm_pc;
        w_insn   <= i_xm_insn;
        w_result <= i_xm_result;
        w_rdata  <= i_dmem_rdata;
    end

    assign o_w_data = o_w_ctrl.is_load ? w_rdata : w_result;

    assign o_retire.valid = o_w_ctrl.valid;
    assign o_retire.pc    = w_pc;
    assign o_retire.insn  = w_insn;
    assign o_retire.rf_we = o_w_ctrl.rf_we;
    assign o_retire.wsel  = o_w_ctrl.rd_sel;
    assign o_retire.wdata = o_w_data;
    assign o_retire.nzp   = nzp_of(o_w_data);

endmodule

// File: hdl/lc4_core.sv
`timescale 1ns/100ps

module lc4_core (
    input  logic               gwe,
    input  logic               i_arst_n,
    input  lc4_pkg::word_t     i_imem_insn,
    input  lc4_pkg::word_t     i_dmem_rdata,
    output lc4_pkg::word_t     o_imem_addr,
    output lc4_pkg::dmem_req_t o_dmem,
    output lc4_pkg::retire_t   o_retire
);
    import lc4_pkg::*;

    // fetch/decode
    word_t fd_pc;
    word_t fd_insn;
    logic  fd_valid;
    logic  stall;
    logic  redirect;
    word_t target;

    // decode/execute
    ctrl_t dx_ctrl;
    word_t dx_pc;
    word_t dx_insn;
    word_t dx_rs;
    word_t dx_rt;

    // execute/memory
    ctrl_t xm_ctrl;
    word_t xm_pc;
    word_t xm_insn;
    word_t xm_result;
    word_t xm_store;

    // writeback and bypass
    logic  load_nzp_we;
    nzp_t  load_nzp;
    ctrl_t w_ctrl;
    word_t w_data;

    fetch_unit fetch_i (
        .gwe        (gwe),
        .i_arst_n   (i_arst_n),
        .i_stall    (stall),
        .i_redirect (redirect),
        .i_target   (target),
        .i_imem_insn(i_imem_insn),
        .o_imem_addr(o_imem_addr),
        .o_fd_pc    (fd_pc),
        .o_fd_insn  (fd_insn),
        .o_fd_valid (fd_valid)
    );

    decode_stage decode_i (
        .gwe       (gwe),
        .i_arst_n  (i_arst_n),
        .i_fd_pc   (fd_pc),
        .i_fd_insn (fd_insn),
        .i_fd_valid(fd_valid),
        .i_redirect(redirect),
        .i_wb_we   (w_ctrl.rf_we),
        .i_wb_sel  (w_ctrl.rd_sel),
        .i_wb_data (w_data),
        .o_stall   (stall),
        .o_dx_ctrl (dx_ctrl),
        .o_dx_pc   (dx_pc),
        .o_dx_insn (dx_insn),
        .o_dx_rs   (dx_rs),
        .o_dx_rt   (dx_rt)
    );

    exec_stage exec_i (
        .gwe          (gwe),
        .i_arst_n     (i_arst_n),
        .i_dx_ctrl    (dx_ctrl),
        .i_dx_pc      (dx_pc),
        .i_dx_insn    (dx_insn),
        .i_dx_rs      (dx_rs),
        .i_dx_rt      (dx_rt),
        .i_m_ctrl     (xm_ctrl),
        .i_m_result   (xm_result),
        .i_w_ctrl     (w_ctrl),
        .i_w_data     (w_data),
        .i_load_nzp_we(load_nzp_we),
        .i_load_nzp   (load_nzp),
        .o_redirect   (redirect),
        .o_target     (target),
        .o_xm_ctrl    (xm_ctrl),
        .o_xm_pc      (xm_pc),
        .o_xm_insn    (xm_insn),
        .o_xm_result  (xm_result),
        .o_xm_store   (xm_store)
    );

    mem_wb_stage mem_wb_i (
        .gwe          (gwe),
        .i_arst_n     (i_arst_n),
        .i_xm_ctrl    (xm_ctrl),
        .i_xm_pc      (xm_pc),
        .i_xm_result  (xm_result),
        .i_xm_store   (xm_store),
        .i_xm_insn    (xm_insn),
        .i_dmem_rdata (i_dmem_rdata),
        .o_dmem       (o_dmem),
        .o_load_nzp_we(load_nzp_we),
        .o_load_nzp   (load_nzp),
        .o_w_ctrl     (w_ctrl),
        .o_w_data     (w_data),
        .o_retire     (o_retire)
    );

endmodule

// File: bench/lc4_core_props.sv
`timescale 1ns/100ps

module lc4_core_props (
    input logic           gwe,
    input logic           i_arst_n,
    input logic           i_retire_valid,
    input logic           i_dmem_we,
    input lc4_pkg::ctrl_t i_xm_ctrl,
    input lc4_pkg::word_t i_xm_insn,
    input logic           i_stall,
    input logic           i_redirect,
    input lc4_pkg::word_t i_imem_addr
);
    import lc4_pkg::*;

    int fail_count = 0;

    a_reset_quiet: assert property (@(posedge gwe) !i_arst_n |-> !i_retire_valid)
        else begin
            $error("retire valid while in reset");
            fail_count++;
        end

    // the word sitting in M must really be a STR
    a_store_in_m: assert property (@(posedge gwe) disable iff (!i_arst_n)
        i_dmem_we |-> (i_xm_ctrl.valid && i_xm_insn[15:12] == OP_STR))
        else begin
            $error("dmem write without a valid store in M");
            fail_count++;
        end

    // a redirect overrides the stall
    a_stall_hold: assert property (@(posedge gwe) disable iff (!i_arst_n)
        (i_stall && !i_redirect) |=> $stable(i_imem_addr))
        else begin
            $error("fetch address moved during a stall");
            fail_count++;
        end

endmodule

// File: bench/lc4_core_checker.sv
`timescale 1ns/100ps

module lc4_core_checker #(
    parameter int N_RET = 1,
    parameter int N_ST  = 1
) (
    input  logic               gwe,
    input  logic               i_arst_n,
    input  lc4_pkg::word_t     i_imem_addr,
    input  lc4_pkg::dmem_req_t i_dmem,
    input  lc4_pkg::retire_t   i_retire,
    input  logic [54:0]        i_exp_retire [N_RET],
    input  logic [31:0]        i_exp_store [N_ST],
    output logic               o_done,
    output int                 o_checks,
    output int                 o_errors
);
    import lc4_pkg::*;

    int   ret_idx;
    int   st_idx;
    logic first_seen;

    task automatic compare_value(string name, int idx, logic [15:0] exp_v,
                                 logic [15:0] act_v);
        o_checks++;
        if (exp_v !== act_v) begin
            o_errors++;
            $display("Error %s [%0d]: expected %h, actual %h", name, idx, exp_v, act_v);
        end
    endtask

    initial begin
        ret_idx    = 0;
        st_idx     = 0;
        first_seen = 1'b0;
        o_checks   = 0;
        o_errors   = 0;
    end

    assign o_done = (ret_idx == N_RET) && (st_idx == N_ST);

    // sample mid-cycle when every output has settled
    always @(negedge gwe) begin : watch
        logic [54:0] er;
        logic [31:0] es;
        if (i_arst_n) begin
            if (!first_seen) begin
                compare_value("first fetch addr", 0, RESET_PC, i_imem_addr);
                compare_value("retire before fetch", 0, 16'h0, 16'(i_retire.valid));
                first_seen = 1'b1;
            end
            // retires past the table come from the parking loop
            if (i_retire.valid && ret_idx < N_RET) begin
                er = i_exp_retire[ret_idx];
                compare_value("retire pc", ret_idx, er[54:39], i_retire.pc);
                compare_value("retire insn", ret_idx, er[38:23], i_retire.insn);
                compare_value("retire rf_we", ret_idx, 16'(er[22]), 16'(i_retire.rf_we));
                if (er[22]) begin
                    compare_value("retire wsel", ret_idx, 16'(er[21:19]),
                                  16'(i_retire.wsel));
                    compare_value("retire wdata", ret_idx, er[18:3], i_retire.wdata);
                    compare_value("retire nzp", ret_idx, 16'(er[2:0]), 16'(i_retire.nzp));
                end
                ret_idx++;
            end
            if (i_dmem.we) begin
                if (st_idx < N_ST) begin
                    es = i_exp_store[st_idx];
                    compare_value("store addr", st_idx, es[31:16], i_dmem.addr);
                    compare_value("store data", st_idx, es[15:0], i_dmem.wdata);
                    st_idx++;
                end else begin
                    o_errors++;
                    $display("unexpected extra store to address %h", i_dmem.addr);
                end
            end
        end
    end

endmodule

// File: bench/lc4_core_tb.sv
`timescale 1ns/100ps

module lc4_core_tb;
    import lc4_pkg::*;

    localparam int N_PROG  = 16;
    localparam int N_RET   = 14;
    localparam int N_ST    = 1;
    localparam int TIMEOUT = 400;

    logic      gwe;
    logic      i_arst_n;
    word_t     imem_insn;
    word_t     dmem_rdata;
    word_t     imem_addr;
    dmem_req_t dmem;
    retire_t   retire;

    word_t imem [65536];
    word_t dmem_arr [65536];

    // program rows {addr, insn}
    logic [31:0] prog [N_PROG];
    // expected retire rows {pc, insn, rf_we, wsel, wdata, nzp}
    logic [54:0] exp_retire [N_RET];
    // expected store rows {addr, data}
    logic [31:0] exp_store [N_ST];

    logic done;
    int   checks;
    int   errors;
    int   timeouts;
    int   cycles;

    // instruction word the program places at an address
    function automatic word_t insn_at(word_t pc);
        for (int i = 0; i < N_PROG; i++) begin
            if (prog[i][31:16] == pc) begin
                return prog[i][15:0];
            end
        end
        return '0;
    endfunction

    function automatic logic [54:0] retire_row(word_t pc, logic we, reg_sel_t sel,
                                               word_t data, nzp_t nzp);
        return {pc, insn_at(pc), we, sel, data, nzp};
    endfunction

    lc4_core dut_i (
        .gwe         (gwe),
        .i_arst_n    (i_arst_n),
        .i_imem_insn (imem_insn),
        .i_dmem_rdata(dmem_rdata),
        .o_imem_addr (imem_addr),
        .o_dmem      (dmem),
        .o_retire    (retire)
    );

    lc4_core_checker #(.N_RET(N_RET), .N_ST(N_ST)) checker_i (
        .gwe         (gwe),
        .i_arst_n    (i_arst_n),
        .i_imem_addr (imem_addr),
        .i_dmem      (dmem),
        .i_retire    (retire),
        .i_exp_retire(exp_retire),
        .i_exp_store (exp_store),
        .o_done      (done),
        .o_checks    (checks),
        .o_errors    (errors)
    );

    bind lc4_core lc4_core_props props_i (
        .gwe           (gwe),
        .i_arst_n      (i_arst_n),
        .i_retire_valid(o_retire.valid),
        .i_dmem_we     (o_dmem.we),
        .i_xm_ctrl     (xm_ctrl),
        .i_xm_insn     (xm_insn),
        .i_stall       (stall),
        .i_redirect    (redirect),
        .i_imem_addr   (o_imem_addr)
    );

    initial begin
        gwe = 1'b0;
        forever #2 gwe = ~gwe;
    end

    // memories answer 1 ns after the edge and the store lands before the read
    always @(posedge gwe) begin
        #1;
        if (dmem.we) begin
            dmem_arr[dmem.addr] = dmem.wdata;
        end
        imem_insn  = imem[imem_addr];
        dmem_rdata = dmem_arr[dmem.addr];
    end

    task automatic fill_tables();
        // arithmetic chain through MX and WX
        prog[0]  = {16'h8200, 16'h9205};
        prog[1]  = {16'h8201, 16'h1441};
        prog[2]  = {16'h8202, 16'h1691};
        prog[3]  = {16'h8203, 16'h18F9};
        // store then load back and use the load right away
        prog[4]  = {16'h8204, 16'h9A40};
        prog[5]  = {16'h8205, 16'h7942};
        prog[6]  = {16'h8206, 16'h6D42};
        prog[7]  = {16'h8207, 16'h1F81};
        // load then a BRn that jumps over two CONSTs
        prog[8]  = {16'h8208, 16'h6542};
        prog[9]  = {16'h8209, 16'h0802};
        prog[10] = {16'h820A, 16'h9201};
        prog[11] = {16'h820B, 16'h9202};
        // BRz falls through and R1 still holds 5
        prog[12] = {16'h820C, 16'h0401};
        prog[13] = {16'h820D, 16'h1660};
        prog[14] = {16'h820E, 16'h18D3};
        // self loop parks the core
        prog[15] = {16'h820F, 16'h0FFF};

        exp_retire[0]  = retire_row(16'h8200, 1'b1, 3'd1, 16'h0005, 3'b001);
        exp_retire[1]  = retire_row(16'h8201, 1'b1, 3'd2, 16'h000A, 3'b001);
        exp_retire[2]  = retire_row(16'h8202, 1'b1, 3'd3, 16'h0005, 3'b001);
        exp_retire[3]  = retire_row(16'h8203, 1'b1, 3'd4, 16'hFFFE, 3'b100);
        exp_retire[4]  = retire_row(16'h8204, 1'b1, 3'd5, 16'h0040, 3'b001);
        exp_retire[5]  = retire_row(16'h8205, 1'b0, 3'd0, 16'h0000, 3'b000);
        exp_retire[6]  = retire_row(16'h8206, 1'b1, 3'd6, 16'hFFFE, 3'b100);
        exp_retire[7]  = retire_row(16'h8207, 1'b1, 3'd7, 16'h0003, 3'b001);
        exp_retire[8]  = retire_row(16'h8208, 1'b1, 3'd2, 16'hFFFE, 3'b100);
        exp_retire[9]  = retire_row(16'h8209, 1'b0, 3'd0, 16'h0000, 3'b000);
        exp_retire[10] = retire_row(16'h820C, 1'b0, 3'd0, 16'h0000, 3'b000);
        exp_retire[11] = retire_row(16'h820D, 1'b1, 3'd3, 16'h0005, 3'b001);
        exp_retire[12] = retire_row(16'h820E, 1'b1, 3'd4, 16'h0000, 3'b010);
        exp_retire[13] = retire_row(16'h820F, 1'b0, 3'd0, 16'h0000, 3'b000);

        exp_store[0] = {16'h0042, 16'hFFFE};
    endtask

    initial begin
        i_arst_n   = 1'b0;
        imem_insn  = '0;
        dmem_rdata = '0;
        timeouts   = 0;
        cycles     = 0;
        fill_tables();
        for (int a = 0; a < 65536; a++) begin
            imem[a]     = '0;
            dmem_arr[a] = word_t'(a) ^ 16'h5A5A;
        end
        for (int i = 0; i < N_PROG; i++) begin
            imem[prog[i][31:16]] = prog[i][15:0];
        end

        repeat (8) @(posedge gwe);
        #1 i_arst_n = 1'b1;

        while (!done && cycles < TIMEOUT) begin
            @(posedge gwe);
            cycles++;
        end
        if (!done) begin
            $display("timeout: retire and store sequence not complete after %0d cycles",
                     TIMEOUT);
            timeouts = 1;
        end

        $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 checks, errors, timeouts, dut_i.props_i.fail_count);
        if (errors == 0 && timeouts == 0 && dut_i.props_i.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: list.f
hdl/lc4_pkg.sv
hdl/fetch_unit.sv
hdl/regfile.sv
hdl/decode_stage.sv
hdl/exec_stage.sv
hdl/mem_wb_stage.sv
hdl/lc4_core.sv
bench/lc4_core_props.sv
bench/lc4_core_checker.sv
bench/lc4_core_tb.sv

// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f list.f --top-module lc4_core_tb -Mdir obj_dir -o sim

run: compile
	-./obj_dir/sim > run.log 2>&1
	cat run.log
	@if grep -q "Some tests failed" run.log; then exit 1; fi
	@grep -q "All tests passed" run.log

clean:
	rm -rf obj_dir run.log
